// File: logic/rv_alu_config.svh
`ifndef RV_ALU_CONFIG_SVH
`define RV_ALU_CONFIG_SVH

// Number of ALU lanes, 1 to 8.
`define RV_ALU_LANES 4

// Set to 1 for the RV32M operations, 0 to report them as illegal.
`define RV_ALU_MULDIV 1

// Region codes in address bits 7:6.
`define RV_ALU_REGION_A   2'b00
`define RV_ALU_REGION_B   2'b01
`define RV_ALU_REGION_RES 2'b10
`define RV_ALU_REGION_CTL 2'b11

// Word offsets inside the control region.
`define RV_ALU_CTL_CMD    4'd0
`define RV_ALU_CTL_STATUS 4'd1

`endif

// File: logic/rv_alu_pkg.sv
`default_nettype none

package rv_alu_pkg;

    // ============================================================
    // Data and instruction field types
    // ============================================================

    // Operands, results and bus data words.
    typedef logic [31:0] word_t;

    // Fields taken from an RV32 OP or OP-IMM instruction word.
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] shamt_t;

    // ============================================================
    // Bus types
    // ============================================================

    // Byte address on the Wishbone port.
    typedef logic [7:0] bus_addr_t;

    // Address bits 7:6 select the region and bits 5:2 the word in it.
    typedef logic [1:0] region_t;
    typedef logic [3:0] word_idx_t;

    // Issue sequencer in the dispatcher.
    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait
    } disp_state_t;

endpackage

`default_nettype wire

// File: logic/rv_alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_config.svh"

module rv_alu_lane
    import rv_alu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    issue,
    input  logic    is_op,
    input  logic    is_op_imm,
    input  funct3_t funct3,
    input  funct7_t funct7,
    input  shamt_t  shamt,
    input  word_t   simm12,
    input  word_t   rs1,
    input  word_t   rs2,
    output word_t   result,
    output logic    valid,
    output logic    illegal
);

    localparam bit      muldiv_en = (`RV_ALU_MULDIV != 0);
    localparam funct7_t f7_base   = 7'b0000000;
    localparam funct7_t f7_alt    = 7'b0100000;
    localparam funct7_t f7_muldiv = 7'b0000001;
    localparam word_t   most_neg  = 32'h8000_0000;

    word_t       op2;
    shamt_t      sh;
    logic [63:0] prod_ss;
    logic [63:0] prod_su;
    logic [63:0] prod_uu;
    logic        div_zero;
    logic        div_ovf;
    logic        base_form;
    word_t       calc;
    logic        calc_illegal;

    assign op2 = is_op ? rs2 : simm12;
    assign sh  = is_op_imm ? shamt : rs2[4:0];

    // Operands are extended to 64 bits by hand, so a plain product
    // modulo 2^64 gives the signed, mixed and unsigned high halves.
    assign prod_ss = {{32{rs1[31]}}, rs1} * {{32{rs2[31]}}, rs2};
    assign prod_su = {{32{rs1[31]}}, rs1} * {32'b0, rs2};
    assign prod_uu = {32'b0, rs1} * {32'b0, rs2};

    assign div_zero = (rs2 == '0);
    assign div_ovf  = (rs1 == most_neg) && (rs2 == '1);

    // OP-IMM and the funct7=0 half of OP share one operation table.
    assign base_form = is_op_imm || (is_op && (funct7 == f7_base));

    // ============================================================
    // Operation decode and compute
    // ============================================================
    always_comb begin
        calc         = rs1 + op2;
        calc_illegal = 1'b0;
        if (base_form) begin
            case (funct3)
                3'b000: calc = rs1 + op2;
                3'b010: calc = {31'b0, ($signed(rs1) < $signed(op2))};
                3'b011: calc = {31'b0, (rs1 < op2)};
                3'b100: calc = rs1 ^ op2;
                3'b110: calc = rs1 | op2;
                3'b111: calc = rs1 & op2;
                3'b001: begin
                    if (funct7 == f7_base) begin
                        calc = rs1 << sh;
                    end else begin
                        calc_illegal = 1'b1;
                    end
                end
                3'b101: begin
                    if (funct7 == f7_base) begin
                        calc = rs1 >> sh;
                    end else if (is_op_imm && (funct7 == f7_alt)) begin
                        calc = $signed(rs1) >>> sh;
                    end else begin
                        calc_illegal = 1'b1;
                    end
                end
                default: calc_illegal = 1'b1;
            endcase
        end else if (is_op && (funct7 == f7_alt)) begin
            case (funct3)
                3'b000:  calc = rs1 - rs2;
                3'b101:  calc = $signed(rs1) >>> sh;
                default: calc_illegal = 1'b1;
            endcase
        end else if (muldiv_en && is_op && (funct7 == f7_muldiv)) begin
            case (funct3)
                3'b000: calc = prod_ss[31:0];
                3'b001: calc = prod_ss[63:32];
                3'b010: calc = prod_su[63:32];
                3'b011: calc = prod_uu[63:32];
                3'b100: begin
                    if (div_zero) begin
                        calc = '1;
                    end else if (div_ovf) begin
                        calc = most_neg;
                    end else begin
                        calc = $signed(rs1) / $signed(rs2);
                    end
                end
                3'b101: begin
                    if (div_zero) begin
                        calc = '1;
                    end else begin
                        calc = rs1 / rs2;
                    end
                end
                3'b110: begin
                    if (div_zero) begin
                        calc = rs1;
                    end else if (div_ovf) begin
                        calc = '0;
                    end else begin
                        calc = $signed(rs1) % $signed(rs2);
                    end
                end
                default: begin
                    if (div_zero) begin
                        calc = rs1;
                    end else begin
                        calc = rs1 % rs2;
                    end
                end
            endcase
        end else begin
            // Unknown opcode or funct7, M operations when they are off.
            calc_illegal = 1'b1;
        end
    end

    // ============================================================
    // Result register
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= 1'b0;
            illegal <= 1'b0;
        end else begin
            valid <= issue;
            if (issue) begin
                illegal <= calc_illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result <= calc;
        end
    end

    valid_after_issue: assert property (
        @(posedge clk) disable iff (rst) valid |-> $past(issue)
    );

endmodule

`default_nettype wire

// File: logic/alu_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_config.svh"

module alu_dispatch
    import rv_alu_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  bus_addr_t                     wb_adr,
    input  word_t                         wb_dat_w,
    output logic                          wb_ack,
    output region_t                       rd_region,
    output word_idx_t                     rd_index,
    output word_t                         op_rd_data,
    output logic                          issue,
    output logic                          is_op,
    output logic                          is_op_imm,
    output funct3_t                       funct3,
    output funct7_t                       funct7,
    output shamt_t                        shamt,
    output word_t                         simm12,
    output word_t [`RV_ALU_LANES-1:0]     rs1_bus,
    output word_t [`RV_ALU_LANES-1:0]     rs2_bus,
    output logic                          clear
);

    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    disp_state_t                  state;
    word_t [`RV_ALU_LANES-1:0]    bank_a;
    word_t [`RV_ALU_LANES-1:0]    bank_b;
    word_t                        cmd_word;
    logic                         req;
    logic                         cmd_hit;
    logic                         cmd_accept;
    logic                         bus_accept;

    // A request is seen once; the ack cycle itself is not a new one.
    assign req       = wb_cyc && wb_stb && !wb_ack;
    assign rd_region = wb_adr[7:6];
    assign rd_index  = wb_adr[5:2];
    assign cmd_hit   = (rd_region == `RV_ALU_REGION_CTL) && (rd_index == `RV_ALU_CTL_CMD);

    // A command write waits while an earlier issue is still in flight.
    assign cmd_accept = req && wb_we && cmd_hit && (state == st_idle);
    assign bus_accept = req && (!(wb_we && cmd_hit) || (state == st_idle));

    // ============================================================
    // Bus handshake and issue sequencer
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            issue  <= 1'b0;
            state  <= st_idle;
        end else begin
            wb_ack <= bus_accept;
            issue  <= cmd_accept;
            case (state)
                st_idle: begin
                    if (cmd_accept) begin
                        state <= st_issue;
                    end
                end
                st_issue: state <= st_wait;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_a   <= '0;
            bank_b   <= '0;
            cmd_word <= '0;
        end else begin
            if (req && wb_we) begin
                for (int i = 0; i < `RV_ALU_LANES; i++) begin
                    if (rd_index == i && rd_region == `RV_ALU_REGION_A) begin
                        bank_a[i] <= wb_dat_w;
                    end
                    if (rd_index == i && rd_region == `RV_ALU_REGION_B) begin
                        bank_b[i] <= wb_dat_w;
                    end
                end
            end
            if (cmd_accept) begin
                cmd_word <= wb_dat_w;
            end
        end
    end

    // Read values that live in this block; the collector picks them up.
    always_comb begin
        op_rd_data = '0;
        case (rd_region)
            `RV_ALU_REGION_A: begin
                for (int i = 0; i < `RV_ALU_LANES; i++) begin
                    if (rd_index == i) begin
                        op_rd_data = bank_a[i];
                    end
                end
            end
            `RV_ALU_REGION_B: begin
                for (int i = 0; i < `RV_ALU_LANES; i++) begin
                    if (rd_index == i) begin
                        op_rd_data = bank_b[i];
                    end
                end
            end
            `RV_ALU_REGION_CTL: begin
                if (cmd_hit) begin
                    op_rd_data = cmd_word;
                end
            end
            default: op_rd_data = '0;
        endcase
    end

    // ============================================================
    // Instruction decode, broadcast to every lane
    // ============================================================
    assign is_op     = (cmd_word[6:0] == opcode_op);
    assign is_op_imm = (cmd_word[6:0] == opcode_op_imm);
    assign funct3    = cmd_word[14:12];
    assign funct7    = cmd_word[31:25];
    assign shamt     = cmd_word[24:20];
    assign simm12    = {{20{cmd_word[31]}}, cmd_word[31:20]};

    assign rs1_bus = bank_a;
    assign rs2_bus = bank_b;
    assign clear   = issue;

    ack_needs_strobe: assert property (
        @(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb)
    );

endmodule

`default_nettype wire

// File: logic/alu_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_config.svh"

module alu_collect
    import rv_alu_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic [`RV_ALU_LANES-1:0]      lane_valid,
    input  word_t [`RV_ALU_LANES-1:0]     lane_result,
    input  logic [`RV_ALU_LANES-1:0]      lane_illegal,
    input  region_t                       rd_region,
    input  word_idx_t                     rd_index,
    input  word_t                         op_rd_data,
    output word_t                         rd_data
);

    word_t [`RV_ALU_LANES-1:0] res_bank;
    logic                      done;
    logic                      illegal;
    word_t                     status_word;

    // ============================================================
    // Result and flag capture
    // ============================================================
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RV_ALU_LANES; i++) begin
            if (lane_valid[i]) begin
                res_bank[i] <= lane_result[i];
            end
        end
    end

    // Every lane decodes the same word, so lane 0 speaks for all.
    always_ff @(posedge clk) begin
        if (rst) begin
            done    <= 1'b0;
            illegal <= 1'b0;
        end else if (clear) begin
            done    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            if (&lane_valid) begin
                done <= 1'b1;
            end
            if (lane_valid[0]) begin
                illegal <= lane_illegal[0];
            end
        end
    end

    assign status_word = {30'b0, illegal, done};

    // ============================================================
    // Read data select
    // ============================================================
    always_comb begin
        rd_data = op_rd_data;
        if (rd_region == `RV_ALU_REGION_RES) begin
            rd_data = '0;
            for (int i = 0; i < `RV_ALU_LANES; i++) begin
                if (rd_index == i) begin
                    rd_data = res_bank[i];
                end
            end
        end else if (rd_region == `RV_ALU_REGION_CTL && rd_index == `RV_ALU_CTL_STATUS) begin
            rd_data = status_word;
        end
    end

    // The lanes share one issue pulse and must finish together.
    lanes_in_step: assert property (
        @(posedge clk) disable iff (rst) (lane_valid == '0) || (&lane_valid)
    );

    lanes_agree_illegal: assert property (
        @(posedge clk) disable iff (rst)
        lane_valid[0] |-> ((lane_illegal == '0) || (&lane_illegal))
    );

endmodule

`default_nettype wire

// File: logic/alu_offload_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_config.svh"

module alu_offload_top
    import rv_alu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  bus_addr_t wb_adr,
    input  word_t     wb_dat_w,
    output word_t     wb_dat_r,
    output logic      wb_ack
);

    region_t                      rd_region;
    word_idx_t                    rd_index;
    word_t                        op_rd_data;
    logic                         issue;
    logic                         is_op;
    logic                         is_op_imm;
    funct3_t                      funct3;
    funct7_t                      funct7;
    shamt_t                       shamt;
    word_t                        simm12;
    word_t [`RV_ALU_LANES-1:0]    rs1_bus;
    word_t [`RV_ALU_LANES-1:0]    rs2_bus;
    logic                         clear;
    logic [`RV_ALU_LANES-1:0]     lane_valid;
    word_t [`RV_ALU_LANES-1:0]    lane_result;
    logic [`RV_ALU_LANES-1:0]     lane_illegal;

    alu_dispatch u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .rd_region  (rd_region),
        .rd_index   (rd_index),
        .op_rd_data (op_rd_data),
        .issue      (issue),
        .is_op      (is_op),
        .is_op_imm  (is_op_imm),
        .funct3     (funct3),
        .funct7     (funct7),
        .shamt      (shamt),
        .simm12     (simm12),
        .rs1_bus    (rs1_bus),
        .rs2_bus    (rs2_bus),
        .clear      (clear)
    );

    // One lane per operand pair, all fed by the same decoded word.
    for (genvar i = 0; i < `RV_ALU_LANES; i++) begin : g_lane
        rv_alu_lane u_lane (
            .clk       (clk),
            .rst       (rst),
            .issue     (issue),
            .is_op     (is_op),
            .is_op_imm (is_op_imm),
            .funct3    (funct3),
            .funct7    (funct7),
            .shamt     (shamt),
            .simm12    (simm12),
            .rs1       (rs1_bus[i]),
            .rs2       (rs2_bus[i]),
            .result    (lane_result[i]),
            .valid     (lane_valid[i]),
            .illegal   (lane_illegal[i])
        );
    end

    alu_collect u_collect (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .lane_valid   (lane_valid),
        .lane_result  (lane_result),
        .lane_illegal (lane_illegal),
        .rd_region    (rd_region),
        .rd_index     (rd_index),
        .op_rd_data   (op_rd_data),
        .rd_data      (wb_dat_r)
    );

endmodule

`default_nettype wire

// File: test/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

localparam logic [6:0] opc_op     = 7'b0110011;
localparam logic [6:0] opc_op_imm = 7'b0010011;
localparam word_t      int_min    = 32'h8000_0000;

// ============================================================
// Instruction word builders
// ============================================================

// The register fields are fixed. The coprocessor never looks at them.
function automatic word_t build_op(input funct7_t f7, input funct3_t f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc_op};
endfunction

function automatic word_t build_op_imm(input logic [11:0] imm, input funct3_t f3);
    return {imm, 5'd1, f3, 5'd3, opc_op_imm};
endfunction

// ============================================================
// Golden ALU, returns {illegal, result} for one lane
// ============================================================
function automatic logic [32:0] golden_alu(input word_t insn, input word_t a, input word_t b);
    logic [6:0]         opcode;
    funct3_t            f3;
    funct7_t            f7;
    word_t              src2;
    shamt_t             amt;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] su;
    logic [63:0]        ua;
    logic [63:0]        prod;
    word_t              res;
    logic               bad;

    opcode = insn[6:0];
    f3     = insn[14:12];
    f7     = insn[31:25];
    src2   = (opcode == opc_op) ? b : {{20{insn[31]}}, insn[31:20]};
    amt    = (opcode == opc_op_imm) ? insn[24:20] : b[4:0];
    sa     = {{32{a[31]}}, a};
    sb     = {{32{b[31]}}, b};
    su     = {32'b0, b};
    ua     = {32'b0, a};
    prod   = '0;
    res    = a + src2;
    bad    = 1'b0;

    if (opcode == opc_op_imm || (opcode == opc_op && f7 == 7'h00)) begin
        case (f3)
            3'b000: res = a + src2;
            3'b010: res = ($signed(a) < $signed(src2)) ? 32'd1 : 32'd0;
            3'b011: res = (a < src2) ? 32'd1 : 32'd0;
            3'b100: res = a ^ src2;
            3'b110: res = a | src2;
            3'b111: res = a & src2;
            3'b001: begin
                if (f7 == 7'h00) res = a << amt;
                else bad = 1'b1;
            end
            default: begin
                if (f7 == 7'h00) res = a >> amt;
                else if (opcode == opc_op_imm && f7 == 7'h20) res = $signed(a) >>> amt;
                else bad = 1'b1;
            end
        endcase
    end else if (opcode == opc_op && f7 == 7'h20) begin
        if (f3 == 3'b000) res = a - b;
        else if (f3 == 3'b101) res = $signed(a) >>> amt;
        else bad = 1'b1;
    end else if (opcode == opc_op && f7 == 7'h01 && `RV_ALU_MULDIV != 0) begin
        case (f3)
            3'b000: begin
                prod = sa * sb;
                res  = prod[31:0];
            end
            3'b001: begin
                prod = sa * sb;
                res  = prod[63:32];
            end
            3'b010: begin
                prod = sa * su;
                res  = prod[63:32];
            end
            3'b011: begin
                prod = ua * su;
                res  = prod[63:32];
            end
            // Division by zero and the one signed overflow case follow the ISA rules.
            3'b100: begin
                if (b == 32'd0) res = 32'hffff_ffff;
                else if (a == int_min && b == 32'hffff_ffff) res = int_min;
                else res = $signed(a) / $signed(b);
            end
            3'b101: res = (b == 32'd0) ? 32'hffff_ffff : a / b;
            3'b110: begin
                if (b == 32'd0) res = a;
                else if (a == int_min && b == 32'hffff_ffff) res = 32'd0;
                else res = $signed(a) % $signed(b);
            end
            default: res = (b == 32'd0) ? a : a % b;
        endcase
    end else begin
        bad = 1'b1;
    end
    return {bad, res};
endfunction

`endif

// File: test/alu_offload_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_alu_config.svh"

module alu_offload_tb
    import rv_alu_pkg::*;
();

    localparam int lanes    = `RV_ALU_LANES;
    localparam int max_wait = 100;

    // A free request is sampled on the next rising edge and acked in that cycle,
    // so ack shows up at the second falling edge after stb is driven.
    localparam int ack_delay = 2;

    `include "alu_ref_model.svh"

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    bus_addr_t   wb_adr;
    word_t       wb_dat_w;
    word_t       wb_dat_r;
    logic        wb_ack;

    logic [31:0] lfsr_state;
    int          errors;
    int          timeouts;
    int          checks;
    word_t       op_a [lanes];
    word_t       op_b [lanes];
    word_t       rd_val;

    alu_offload_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #4 clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================
    function automatic bus_addr_t reg_addr(input logic [1:0] region, input int index);
        return {region, index[3:0], 2'b00};
    endfunction

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_for_ack(input string what, input int delay);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < max_wait);
        if (!wb_ack) begin
            timeouts++;
            $display("The bus %s at %0t got no ack within %0d cycles.", what, $time, max_wait);
        end else begin
            check_value($sformatf("wb_ack delay of %s", what), n, delay);
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input word_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        wait_for_ack("write", ack_delay);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        wait_for_ack("read", ack_delay);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // Corner mode puts a zero divisor or INT_MIN / -1 into most lanes.
    task automatic load_operands(input bit corner);
        for (int i = 0; i < lanes; i++) begin
            take_bits(32, op_a[i]);
            take_bits(32, op_b[i]);
            if (corner && i % 3 == 0) begin
                op_b[i] = '0;
            end else if (corner && i % 3 == 1) begin
                op_a[i] = int_min;
                op_b[i] = '1;
            end
            bus_write(reg_addr(`RV_ALU_REGION_A, i), op_a[i]);
            bus_write(reg_addr(`RV_ALU_REGION_B, i), op_b[i]);
        end
    endtask

    task automatic verify_results(input word_t insn, input string label);
        logic [32:0] model;
        word_t       status;
        int          n;
        n = 0;
        do begin
            bus_read(reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_STATUS), status);
            n++;
        end while (!status[0] && n < max_wait);
        if (!status[0]) begin
            timeouts++;
            $display("%s never reported done within %0d status polls.", label, max_wait);
        end
        model = golden_alu(insn, op_a[0], op_b[0]);
        check_value($sformatf("%s status", label), status, {30'b0, model[32], 1'b1});
        for (int i = 0; i < lanes; i++) begin
            model = golden_alu(insn, op_a[i], op_b[i]);
            bus_read(reg_addr(`RV_ALU_REGION_RES, i), rd_val);
            check_value($sformatf("%s result[%0d]", label, i), rd_val, model[31:0]);
        end
    endtask

    task automatic op_round(input word_t insn, input string label, input bit corner);
        load_operands(corner);
        bus_write(reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_CMD), insn);
        verify_results(insn, label);
    endtask

    // Second command is presented while the first is still in flight.
    // The dispatcher sits in issue and then wait, so the second ack comes
    // one cycle later than it would for a free write.
    task automatic command_pair(input word_t first, input word_t second);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_CMD);
        wb_dat_w <= first;
        wait_for_ack("first command write", ack_delay);
        @(posedge clk);
        wb_dat_w <= second;
        wait_for_ack("second command write", ack_delay + 1);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // ============================================================
    // Scenario
    // ============================================================
    initial begin
        word_t       tmp;
        logic [32:0] xor_model;
        logic [11:0] imm;
        shamt_t      sh;

        clk        = 1'b0;
        rst        = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        lfsr_state = 32'h222a52ae;
        errors     = 0;
        timeouts   = 0;
        checks     = 0;

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        bus_read(reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_STATUS), rd_val);
        check_value("status after reset", rd_val, 32'd0);
        bus_read(reg_addr(`RV_ALU_REGION_A, 0), rd_val);
        check_value("bank A[0] after reset", rd_val, 32'd0);

        // Register-register RV32I.
        for (int rep = 0; rep < 3; rep++) begin
            op_round(build_op(7'h00, 3'b000), "ADD", 0);
            op_round(build_op(7'h20, 3'b000), "SUB", 0);
            op_round(build_op(7'h00, 3'b010), "SLT", 0);
            op_round(build_op(7'h00, 3'b011), "SLTU", 0);
            op_round(build_op(7'h00, 3'b100), "XOR", 0);
            op_round(build_op(7'h00, 3'b110), "OR", 0);
            op_round(build_op(7'h00, 3'b111), "AND", 0);
            op_round(build_op(7'h00, 3'b001), "SLL", 0);
            op_round(build_op(7'h00, 3'b101), "SRL", 0);
            op_round(build_op(7'h20, 3'b101), "SRA", 0);
        end

        // Immediate forms. Even rounds force a negative immediate.
        for (int rep = 0; rep < 4; rep++) begin
            take_bits(12, tmp);
            imm = tmp[11:0];
            if (rep % 2 == 0) imm[11] = 1'b1;
            op_round(build_op_imm(imm, 3'b000), "ADDI", 0);
            op_round(build_op_imm(imm, 3'b010), "SLTI", 0);
            op_round(build_op_imm(imm, 3'b011), "SLTIU", 0);
            op_round(build_op_imm(imm, 3'b100), "XORI", 0);
            op_round(build_op_imm(imm, 3'b110), "ORI", 0);
            op_round(build_op_imm(imm, 3'b111), "ANDI", 0);
            take_bits(5, tmp);
            sh = (rep == 0) ? 5'd0 : (rep == 1) ? 5'd31 : tmp[4:0];
            op_round(build_op_imm({7'h00, sh}, 3'b001), "SLLI", 0);
            op_round(build_op_imm({7'h00, sh}, 3'b101), "SRLI", 0);
            op_round(build_op_imm({7'h20, sh}, 3'b101), "SRAI", 0);
        end

        // Multiply and divide with random operands first and corner operands second.
        for (int rep = 0; rep < 2; rep++) begin
            op_round(build_op(7'h01, 3'b000), "MUL", rep[0]);
            op_round(build_op(7'h01, 3'b001), "MULH", rep[0]);
            op_round(build_op(7'h01, 3'b010), "MULHSU", rep[0]);
            op_round(build_op(7'h01, 3'b011), "MULHU", rep[0]);
            op_round(build_op(7'h01, 3'b100), "DIV", rep[0]);
            op_round(build_op(7'h01, 3'b101), "DIVU", rep[0]);
            op_round(build_op(7'h01, 3'b110), "REM", rep[0]);
            op_round(build_op(7'h01, 3'b111), "REMU", rep[0]);
        end

        // Illegal encodings.
        take_bits(32, tmp);
        op_round(build_op(7'h02, tmp[2:0]), "bad funct7", 0);
        op_round({tmp[31:7], 7'b0110111}, "bad opcode", 0);
        op_round(build_op_imm({7'h20, 5'd3}, 3'b001), "SLLI with funct7", 0);
        op_round(build_op_imm({7'h01, 5'd4}, 3'b101), "SRLI with funct7", 0);

        // Bus behavior.
        load_operands(0);
        for (int i = 0; i < lanes; i++) begin
            bus_read(reg_addr(`RV_ALU_REGION_A, i), rd_val);
            check_value($sformatf("bank A[%0d]", i), rd_val, op_a[i]);
            bus_read(reg_addr(`RV_ALU_REGION_B, i), rd_val);
            check_value($sformatf("bank B[%0d]", i), rd_val, op_b[i]);
        end
        op_round(build_op(7'h00, 3'b100), "XOR before readback", 0);
        bus_read(reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_CMD), rd_val);
        check_value("COMMAND readback", rd_val, build_op(7'h00, 3'b100));
        xor_model = golden_alu(build_op(7'h00, 3'b100), op_a[0], op_b[0]);
        bus_write(reg_addr(`RV_ALU_REGION_RES, 0), ~xor_model[31:0]);
        bus_read(reg_addr(`RV_ALU_REGION_RES, 0), rd_val);
        check_value("result[0] after write", rd_val, xor_model[31:0]);
        bus_write(reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_STATUS), ~32'd1);
        bus_read(reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_STATUS), rd_val);
        check_value("status after write", rd_val, 32'd1);

        // Back-pressure on a second command.
        load_operands(0);
        command_pair(build_op(7'h00, 3'b000), build_op(7'h20, 3'b000));
        verify_results(build_op(7'h20, 3'b000), "back to back SUB");
        bus_read(reg_addr(`RV_ALU_REGION_CTL, `RV_ALU_CTL_CMD), rd_val);
        check_value("COMMAND after pair", rd_val, build_op(7'h20, 3'b000));

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: alu_offload_top.f
+incdir+logic
+incdir+test
logic/rv_alu_pkg.sv
logic/rv_alu_lane.sv
logic/alu_dispatch.sv
logic/alu_collect.sv
logic/alu_offload_top.sv
test/alu_offload_tb.sv

// File: Bender.yml
package:
  name: alu_offload

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_alu_pkg.sv
      - logic/rv_alu_lane.sv
      - logic/alu_dispatch.sv
      - logic/alu_collect.sv
      - logic/alu_offload_top.sv

  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/alu_offload_tb.sv
